// File: crc32_d64.sv
`timescale 1ns/1ps

module crc32_d64 import mac_tx_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_start,
  input  logic  i_en,
  input  data_t i_data,
  input  keep_t i_keep,
  output crc_t  o_crc
);

  crc_t crc_q;
  crc_t crc_base;
  crc_t crc_fin;

  // Byte-serial reflected CRC from lane 0 up and LSB first within a byte
  function automatic crc_t crc_fold(crc_t crc_in, data_t data, keep_t keep);
    crc_t c;
    c = crc_in;
    for (int lane = 0; lane < 8; lane++) begin
      if (keep[7 - lane]) begin
        c = c ^ {24'h0, data[63 - 8*lane -: 8]};
        for (int b = 0; b < 8; b++) begin
          if (c[0]) begin
            c = (c >> 1) ^ CRC_POLY;
          end else begin
            c = c >> 1;
          end
        end
      end
    end
    return c;
  endfunction

  assign crc_base = i_start ? CRC_INIT : crc_q;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      crc_q <= CRC_INIT;
    end else if (i_en) begin
      crc_q <= crc_fold(crc_base, i_data, i_keep);
    end else if (i_start) begin
      crc_q <= CRC_INIT;
    end
  end

  assign crc_fin = ~crc_q;

  // First byte on the wire in the top lane
  assign o_crc = {crc_fin[7:0], crc_fin[15:8], crc_fin[23:16], crc_fin[31:24]};

endmodule

// File: mac_tx_pkg.sv
package mac_tx_pkg;

  ////////////////////
  // Widths

  typedef logic [63:0] data_t;
  typedef logic [7:0]  keep_t;
  typedef logic [7:0]  xgmii_ctrl_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] eth_type_t;
  typedef logic [31:0] crc_t;
  typedef logic [5:0]  beat_cnt_t;

  // One per stored frame
  typedef struct packed {
    beat_cnt_t beats;
    keep_t     tail_keep;
    eth_type_t eth_type;
  } frame_desc_t;

  // Framer output beat with lane 0 in the top byte
  typedef struct packed {
    data_t data;
    keep_t keep;
    logic  sof;
    logic  eof;
    logic  crc_en;
  } fr_beat_t;

  typedef enum logic [2:0] {
    IDLE,
    PREAMBLE,
    HEADER,
    PAYLOAD,
    TAIL,
    GAP
  } framer_state_e;

  ////////////////////
  // Constants

  localparam logic [7:0] XGMII_IDLE  = 8'h07;
  localparam logic [7:0] XGMII_START = 8'hFB;
  localparam logic [7:0] XGMII_TERM  = 8'hFD;

  // Start character, six preamble bytes and the SFD
  localparam data_t PREAMBLE_SFD = 64'hFB55_5555_5555_55D5;

  localparam mac_addr_t SRC_MAC = 48'h02_66_77_88_99_AA;
  localparam mac_addr_t DST_MAC = 48'h02_11_22_33_44_55;

  localparam int DATA_FIFO_DEPTH = 256;
  localparam int DATA_AW         = $clog2(DATA_FIFO_DEPTH);
  localparam int DESC_FIFO_DEPTH = 16;
  localparam int DESC_AW         = $clog2(DESC_FIFO_DEPTH);
  localparam int MAX_FRAME_BEATS = 32;

  localparam int IFG_BYTES  = 12;
  localparam int IFG_CYCLES = (IFG_BYTES + 7) / 8;

  localparam crc_t CRC_INIT = 32'hFFFF_FFFF;
  // 04C11DB7 bit-reversed
  localparam crc_t CRC_POLY = 32'hEDB8_8320;

endpackage

// File: project.f
mac_tx_pkg.sv
crc32_d64.sv
tx_frame_buffer.sv
tx_framer.sv
xgmii_tx_encoder.sv
ten_gig_mac_tx.sv
ten_gig_mac_tx_assertions.sv
tb_ten_gig_mac_tx.sv

// File: run.sh
#!/bin/sh
# Compile and run the MAC transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_ten_gig_mac_tx -o sim_tb || exit 1

out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

// File: tb_ten_gig_mac_tx.sv
`timescale 1ns/1ps

module tb_ten_gig_mac_tx import mac_tx_pkg::*; ();

  logic        clk;
  logic        rst;
  data_t       s_tdata;
  keep_t       s_tkeep;
  eth_type_t   s_tuser;
  logic        s_tlast;
  logic        s_tvalid;
  logic        s_tready;
  data_t       xgmii_txd;
  xgmii_ctrl_t xgmii_txc;

  integer seed = 32'h2cba;
  int     errors = 0;
  int     cycles = 0;
  int     limit = 500;
  int     frames_seen = 0;
  int     idle_run = 0;
  logic   in_frame = 1'b0;
  logic   saw_stall = 1'b0;

  // Expected XGMII stream of {control, byte} with lane 0 first
  logic [8:0] exp_q[$];
  logic [7:0] exp_byte [8] = '{default: XGMII_IDLE};
  logic       exp_ctrl [8] = '{default: 1'b1};
  logic [7:0] seen_byte [8];
  logic       seen_ctrl [8];
  logic       gap_short [8] = '{default: 1'b0};

  ten_gig_mac_tx i_ten_gig_mac_tx (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_s_tdata   (s_tdata),
    .i_s_tkeep   (s_tkeep),
    .i_s_tuser   (s_tuser),
    .i_s_tlast   (s_tlast),
    .i_s_tvalid  (s_tvalid),
    .o_s_tready  (s_tready),
    .o_xgmii_txd (xgmii_txd),
    .o_xgmii_txc (xgmii_txc)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // Ethernet CRC-32, reflected, one bit at a time
  function automatic crc_t crc_step(input crc_t crc, input logic [7:0] b);
    crc_t c;
    logic fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      fb = c[0] ^ b[i];
      c  = c >> 1;
      if (fb) begin
        c = c ^ 32'hEDB8_8320;
      end
    end
    return c;
  endfunction

  task automatic push_frame_byte(inout crc_t crc, input logic [7:0] b);
    crc = crc_step(crc, b);
    exp_q.push_back({1'b0, b});
  endtask

  // Starts on a falling edge and returns on the falling edge after the transfer
  task automatic drive_beat(input data_t d, input keep_t k, input logic last,
                            input eth_type_t u, input bit gaps);
    while (gaps && ($random(seed) % 8 == 0)) begin
      s_tvalid = 1'b0;
      @(negedge clk);
    end
    s_tdata  = d;
    s_tkeep  = k;
    s_tlast  = last;
    s_tuser  = u;
    s_tvalid = 1'b1;
    while (!s_tready) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic send_frame(input int nbeats, input int tail_n, input bit gaps);
    data_t     words [32];
    eth_type_t etype;
    crc_t      crc;
    keep_t     tail_keep;
    int        n;
    etype     = eth_type_t'($random(seed));
    tail_keep = keep_t'(8'hFF << (8 - tail_n));
    limit     = limit + nbeats + 6 + IFG_CYCLES;
    crc       = 32'hFFFF_FFFF;
    exp_q.push_back({1'b1, XGMII_START});
    for (int i = 0; i < 6; i++) begin
      exp_q.push_back(9'h055);
    end
    exp_q.push_back(9'h0D5);
    for (int i = 0; i < 6; i++) begin
      push_frame_byte(crc, DST_MAC[47 - 8*i -: 8]);
    end
    for (int i = 0; i < 6; i++) begin
      push_frame_byte(crc, SRC_MAC[47 - 8*i -: 8]);
    end
    push_frame_byte(crc, etype[15:8]);
    push_frame_byte(crc, etype[7:0]);
    for (int w = 0; w < nbeats; w++) begin
      words[w] = {$random(seed), $random(seed)};
      n = (w == nbeats - 1) ? tail_n : 8;
      for (int l = 0; l < n; l++) begin
        push_frame_byte(crc, words[w][63 - 8*l -: 8]);
      end
    end
    // FCS goes out least significant byte first
    crc = ~crc;
    for (int i = 0; i < 4; i++) begin
      exp_q.push_back({1'b0, crc[8*i +: 8]});
    end
    exp_q.push_back({1'b1, XGMII_TERM});
    for (int w = 0; w < nbeats; w++) begin
      drive_beat(words[w], (w == nbeats - 1) ? tail_keep : 8'hFF, w == nbeats - 1,
                 etype, gaps);
    end
    s_tvalid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || in_frame) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
  endtask

  ////////////////////
  // Lane monitor

  // Sets up the expected word for the next rising edge
  always @(negedge clk) begin : lane_monitor
    logic [8:0] word;
    for (int l = 0; l < 8; l++) begin
      seen_byte[l] = xgmii_txd[63 - 8*l -: 8];
      seen_ctrl[l] = xgmii_txc[7 - l];
      gap_short[l] = 1'b0;
      if (!in_frame && seen_byte[l] == XGMII_START && seen_ctrl[l] &&
          exp_q.size() != 0) begin
        in_frame     = 1'b1;
        gap_short[l] = (frames_seen != 0) && (idle_run < IFG_BYTES);
        frames_seen++;
      end
      if (in_frame) begin
        word        = exp_q.pop_front();
        exp_ctrl[l] = word[8];
        exp_byte[l] = word[7:0];
        if (word == {1'b1, XGMII_TERM}) begin
          in_frame = 1'b0;
          idle_run = 0;
        end
      end else begin
        exp_ctrl[l] = 1'b1;
        exp_byte[l] = XGMII_IDLE;
        idle_run++;
      end
    end
  end

  for (genvar l = 0; l < 8; l++) begin : g_lane
    assert property (@(posedge clk) disable iff (rst)
                     xgmii_txd[63 - 8*l -: 8] == exp_byte[l])
      else begin
        errors++;
        $display("FAILED %0t o_xgmii_txd lane %0d expected %h actual %h",
                 $time, l, exp_byte[l], seen_byte[l]);
      end
    assert property (@(posedge clk) disable iff (rst) xgmii_txc[7 - l] == exp_ctrl[l])
      else begin
        errors++;
        $display("FAILED %0t o_xgmii_txc lane %0d expected %b actual %b",
                 $time, l, exp_ctrl[l], seen_ctrl[l]);
      end
    assert property (@(posedge clk) disable iff (rst) !gap_short[l])
      else begin
        errors++;
        $display("Start at %0t in lane %0d came after fewer than %0d idle bytes",
                 $time, l, IFG_BYTES);
      end
  end

  always @(negedge clk) begin
    if (!s_tready) begin
      saw_stall = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout after %0d cycles, %0d bytes never came out", cycles, exp_q.size());
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin : main
    int bound;
    rst      = 1'b1;
    s_tdata  = '0;
    s_tkeep  = '0;
    s_tuser  = '0;
    s_tlast  = 1'b0;
    s_tvalid = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);
    assert (s_tready) else begin
      errors++;
      $display("FAILED %0t o_s_tready expected 1 actual %b", $time, s_tready);
    end

    send_frame(4, 8, 1'b0);
    wait_drain();
    // Every tail keep over two and three beats
    for (int t = 1; t <= 8; t++) begin
      send_frame(2 + t % 2, t, 1'b0);
      wait_drain();
    end
    for (int f = 0; f < 12; f++) begin
      send_frame(rand_range(2, 12), rand_range(1, 8), 1'b0);
    end
    wait_drain();
    // Short frames outrun the output and fill the descriptor FIFO
    for (int f = 0; f < 80; f++) begin
      send_frame(rand_range(2, 8), rand_range(1, 8), 1'b1);
    end
    wait_drain();

    assert (saw_stall) else begin
      errors++;
      $display("o_s_tready never went low while the buffer was overloaded");
    end
    assert (s_tready) else begin
      errors++;
      $display("FAILED %0t o_s_tready expected 1 actual %b", $time, s_tready);
    end
    bound = i_ten_gig_mac_tx.u_encoder.u_xgmii_checks.fail_count +
            i_ten_gig_mac_tx.u_buffer.u_axis_checks.fail_count;
    $display("Errors: %0d testbench checks, %0d bound assertions, %0d frames seen",
             errors, bound, frames_seen);
    if (errors == 0 && bound == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: ten_gig_mac_tx.sv
`timescale 1ns/1ps

module ten_gig_mac_tx import mac_tx_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst,
  input  data_t       i_s_tdata,
  input  keep_t       i_s_tkeep,
  input  eth_type_t   i_s_tuser,
  input  logic        i_s_tlast,
  input  logic        i_s_tvalid,
  output logic        o_s_tready,
  output data_t       o_xgmii_txd,
  output xgmii_ctrl_t o_xgmii_txc
);

  frame_desc_t desc;
  logic        desc_valid;
  logic        desc_pop;
  logic        data_pop;
  data_t       fifo_data;
  fr_beat_t    beat;
  logic        beat_valid;
  crc_t        crc;
  logic        crc_valid;

  tx_frame_buffer u_buffer (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_s_tdata    (i_s_tdata),
    .i_s_tkeep    (i_s_tkeep),
    .i_s_tuser    (i_s_tuser),
    .i_s_tlast    (i_s_tlast),
    .i_s_tvalid   (i_s_tvalid),
    .i_desc_pop   (desc_pop),
    .i_data_pop   (data_pop),
    .o_s_tready   (o_s_tready),
    .o_desc       (desc),
    .o_desc_valid (desc_valid),
    .o_data       (fifo_data)
  );

  tx_framer u_framer (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_desc       (desc),
    .i_desc_valid (desc_valid),
    .i_data       (fifo_data),
    .o_desc_pop   (desc_pop),
    .o_data_pop   (data_pop),
    .o_beat       (beat),
    .o_beat_valid (beat_valid),
    .o_crc        (crc),
    .o_crc_valid  (crc_valid)
  );

  xgmii_tx_encoder u_encoder (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_beat       (beat),
    .i_beat_valid (beat_valid),
    .i_crc        (crc),
    .i_crc_valid  (crc_valid),
    .o_xgmii_txd  (o_xgmii_txd),
    .o_xgmii_txc  (o_xgmii_txc)
  );

endmodule

// File: ten_gig_mac_tx_assertions.sv
`timescale 1ns/1ps

module ten_gig_mac_tx_assertions import mac_tx_pkg::*; (
  input logic               i_clk,
  input logic               i_rst,
  input data_t              i_txd,
  input xgmii_ctrl_t        i_txc,
  input logic [DATA_AW-1:0] i_wr_ptr,
  input logic               i_tready
);

  int   fail_count = 0;
  logic frame_open;
  logic is_start;
  logic has_term;

  ////////////////////
  // XGMII side

  assign is_start = (i_txd[63:56] == XGMII_START) && i_txc[7];

  always_comb begin
    has_term = 1'b0;
    for (int lane = 0; lane < 8; lane++) begin
      if (i_txc[7 - lane] && (i_txd[63 - 8*lane -: 8] == XGMII_TERM)) begin
        has_term = 1'b1;
      end
    end
  end

  // Open from a start word up to the word that carries the terminate
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      frame_open <= 1'b0;
    end else if (has_term) begin
      frame_open <= 1'b0;
    end else if (is_start) begin
      frame_open <= 1'b1;
    end
  end

  assert property (@(posedge i_clk) disable iff (i_rst)
                   !frame_open && !is_start |-> (i_txc == 8'hFF))
    else begin
      fail_count++;
      $error("XGMII control is not all ones while no frame is active");
    end

  assert property (@(posedge i_clk) disable iff (i_rst)
                   !frame_open && !is_start |-> (i_txd == {8{XGMII_IDLE}}))
    else begin
      fail_count++;
      $error("XGMII data is not all idle while no frame is active");
    end

  // A start right after an idle word carries its control bit
  assert property (@(posedge i_clk) disable iff (i_rst)
                   (i_txd[63:56] == XGMII_START) && ($past(i_txc) == 8'hFF) |-> i_txc[7])
    else begin
      fail_count++;
      $error("Start character in lane 0 without its control bit");
    end

  ////////////////////
  // AXI-Stream side

  // A write into the data FIFO needs tready on that edge
  assert property (@(posedge i_clk) disable iff (i_rst)
                   (i_wr_ptr != $past(i_wr_ptr)) |-> $past(i_tready))
    else begin
      fail_count++;
      $error("Input beat accepted while tready is low");
    end

endmodule

bind xgmii_tx_encoder ten_gig_mac_tx_assertions u_xgmii_checks (
  .i_clk    (i_clk),
  .i_rst    (i_rst),
  .i_txd    (o_xgmii_txd),
  .i_txc    (o_xgmii_txc),
  .i_wr_ptr ('0),
  .i_tready (1'b1)
);

bind tx_frame_buffer ten_gig_mac_tx_assertions u_axis_checks (
  .i_clk    (i_clk),
  .i_rst    (i_rst),
  .i_txd    ({8{XGMII_IDLE}}),
  .i_txc    (8'hFF),
  .i_wr_ptr (data_wr_ptr),
  .i_tready (o_s_tready)
);

// File: tx_frame_buffer.sv
`timescale 1ns/1ps

module tx_frame_buffer import mac_tx_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst,
  input  data_t       i_s_tdata,
  input  keep_t       i_s_tkeep,
  input  eth_type_t   i_s_tuser,
  input  logic        i_s_tlast,
  input  logic        i_s_tvalid,
  input  logic        i_desc_pop,
  input  logic        i_data_pop,
  output logic        o_s_tready,
  output frame_desc_t o_desc,
  output logic        o_desc_valid,
  output data_t       o_data
);

  data_t       data_mem [DATA_FIFO_DEPTH];
  frame_desc_t desc_mem [DESC_FIFO_DEPTH];

  logic [DATA_AW-1:0] data_wr_ptr;
  logic [DATA_AW-1:0] data_rd_ptr;
  logic [DATA_AW:0]   data_count;
  logic [DESC_AW-1:0] desc_wr_ptr;
  logic [DESC_AW-1:0] desc_rd_ptr;
  logic [DESC_AW:0]   desc_count;

  beat_cnt_t   beat_cnt;
  frame_desc_t new_desc;
  logic        wr_beat;
  logic        wr_desc;

  assign wr_beat = i_s_tvalid && o_s_tready;
  assign wr_desc = wr_beat && i_s_tlast;

  // Room for one more maximum frame and one more descriptor
  assign o_s_tready = (int'(data_count) <= DATA_FIFO_DEPTH - MAX_FRAME_BEATS) &&
                      (int'(desc_count) != DESC_FIFO_DEPTH);

  assign new_desc.beats     = beat_cnt + beat_cnt_t'(1);
  assign new_desc.tail_keep = i_s_tkeep;
  assign new_desc.eth_type  = i_s_tuser;

  assign o_desc       = desc_mem[desc_rd_ptr];
  assign o_desc_valid = (desc_count != '0);

  ////////////////////
  // Storage

  always_ff @(posedge i_clk) begin
    if (wr_beat) begin
      data_mem[data_wr_ptr] <= i_s_tdata;
    end
    if (wr_desc) begin
      desc_mem[desc_wr_ptr] <= new_desc;
    end
    // Registered read held until the next pop
    if (i_data_pop) begin
      o_data <= data_mem[data_rd_ptr];
    end
  end

  ////////////////////
  // Pointers and fill levels

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      data_wr_ptr <= '0;
      data_rd_ptr <= '0;
      data_count  <= '0;
      desc_wr_ptr <= '0;
      desc_rd_ptr <= '0;
      desc_count  <= '0;
      beat_cnt    <= '0;
    end else begin
      if (wr_beat) begin
        data_wr_ptr <= data_wr_ptr + 1'b1;
      end
      if (i_data_pop) begin
        data_rd_ptr <= data_rd_ptr + 1'b1;
      end
      data_count <= data_count + (DATA_AW+1)'(wr_beat) - (DATA_AW+1)'(i_data_pop);

      if (wr_desc) begin
        desc_wr_ptr <= desc_wr_ptr + 1'b1;
      end
      if (i_desc_pop) begin
        desc_rd_ptr <= desc_rd_ptr + 1'b1;
      end
      desc_count <= desc_count + (DESC_AW+1)'(wr_desc) - (DESC_AW+1)'(i_desc_pop);

      // Beats seen so far in the open frame
      if (wr_beat) begin
        beat_cnt <= i_s_tlast ? '0 : beat_cnt + beat_cnt_t'(1);
      end
    end
  end

endmodule

// File: tx_framer.sv
`timescale 1ns/1ps

module tx_framer import mac_tx_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst,
  input  frame_desc_t i_desc,
  input  logic        i_desc_valid,
  input  data_t       i_data,
  output logic        o_desc_pop,
  output logic        o_data_pop,
  output fr_beat_t    o_beat,
  output logic        o_beat_valid,
  output crc_t        o_crc,
  output logic        o_crc_valid
);

  framer_state_e state;
  beat_cnt_t     cnt;
  frame_desc_t   desc;
  data_t         prev_word;
  logic          last_word;
  logic          short_tail;

  assign last_word  = (cnt == desc.beats - beat_cnt_t'(1));
  // Two tail bytes or fewer fit in the last payload word
  assign short_tail = ~desc.tail_keep[5];

  assign o_desc_pop   = (state == IDLE) && i_desc_valid;
  assign o_data_pop   = (state == HEADER) || ((state == PAYLOAD) && !last_word);
  assign o_beat_valid = (state == PREAMBLE) || (state == HEADER) ||
                        (state == PAYLOAD) || (state == TAIL);

  ////////////////////
  // Frame FSM

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (i_desc_valid) begin
            state <= PREAMBLE;
          end
        end
        PREAMBLE: begin
          state <= HEADER;
          cnt   <= '0;
        end
        HEADER: begin
          if (cnt == '0) begin
            cnt <= beat_cnt_t'(1);
          end else begin
            state <= PAYLOAD;
          end
        end
        PAYLOAD: begin
          if (last_word) begin
            state <= short_tail ? GAP : TAIL;
            cnt   <= '0;
          end else begin
            cnt <= cnt + beat_cnt_t'(1);
          end
        end
        TAIL: begin
          state <= GAP;
        end
        GAP: begin
          if (cnt == beat_cnt_t'(IFG_CYCLES - 1)) begin
            state <= IDLE;
          end else begin
            cnt <= cnt + beat_cnt_t'(1);
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_desc_pop) begin
      desc <= i_desc;
    end
    if (((state == HEADER) && (cnt != '0)) || (state == PAYLOAD)) begin
      prev_word <= i_data;
    end
  end

  ////////////////////
  // Beat assembly with the payload 6 bytes behind the header

  always_comb begin
    o_beat        = '0;
    o_beat.keep   = keep_t'(8'hFF);
    o_beat.crc_en = 1'b1;
    case (state)
      PREAMBLE: begin
        o_beat.data   = PREAMBLE_SFD;
        o_beat.sof    = 1'b1;
        o_beat.crc_en = 1'b0;
      end
      HEADER: begin
        if (cnt == '0) begin
          o_beat.data = {DST_MAC, SRC_MAC[47:32]};
        end else begin
          o_beat.data = {SRC_MAC[31:0], desc.eth_type, i_data[63:48]};
        end
      end
      PAYLOAD: begin
        o_beat.data = {prev_word[47:0], i_data[63:48]};
        if (last_word && short_tail) begin
          o_beat.keep = {6'h3F, desc.tail_keep[7:6]};
          o_beat.eof  = 1'b1;
        end
      end
      TAIL: begin
        o_beat.data = {prev_word[47:0], 16'h0};
        o_beat.keep = {desc.tail_keep[5:0], 2'b00};
        o_beat.eof  = 1'b1;
      end
      default: begin
        o_beat.keep   = '0;
        o_beat.crc_en = 1'b0;
      end
    endcase
  end

  crc32_d64 u_crc (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (state == PREAMBLE),
    .i_en    (o_beat.crc_en),
    .i_data  (o_beat.data),
    .i_keep  (o_beat.keep),
    .o_crc   (o_crc)
  );

  // Final CRC is ready the cycle after the eof beat
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_crc_valid <= 1'b0;
    end else begin
      o_crc_valid <= o_beat_valid && o_beat.eof;
    end
  end

endmodule

// File: xgmii_tx_encoder.sv
`timescale 1ns/1ps

module xgmii_tx_encoder import mac_tx_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst,
  input  fr_beat_t    i_beat,
  input  logic        i_beat_valid,
  input  crc_t        i_crc,
  input  logic        i_crc_valid,
  output data_t       o_xgmii_txd,
  output xgmii_ctrl_t o_xgmii_txc
);

  fr_beat_t     s1_beat;
  logic         s1_valid;
  data_t        pend_txd;
  xgmii_ctrl_t  pend_txc;
  logic         pend_valid;
  logic [127:0] win_txd;
  logic [15:0]  win_txc;
  int           nkeep;
  logic         close;

  assign nkeep = $countones(s1_beat.keep);
  assign close = s1_valid && s1_beat.eof && i_crc_valid;

  ////////////////////
  // Two-word window so CRC and terminate can spill over

  always_comb begin
    win_txd = {s1_beat.data, 64'h0};
    win_txc = '0;
    for (int lane = 0; lane < 16; lane++) begin
      if (lane >= nkeep) begin
        win_txd[127 - 8*lane -: 8] = XGMII_IDLE;
        win_txc[15 - lane]         = 1'b1;
        if (close && (lane < nkeep + 4)) begin
          win_txd[127 - 8*lane -: 8] = i_crc[31 - 8*(lane - nkeep) -: 8];
          win_txc[15 - lane]         = 1'b0;
        end else if (close && (lane == nkeep + 4)) begin
          win_txd[127 - 8*lane -: 8] = XGMII_TERM;
        end
      end
    end
    if (s1_beat.sof) begin
      win_txd[127:120] = XGMII_START;
      win_txc[15]      = 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    s1_beat  <= i_beat;
    pend_txd <= win_txd[63:0];
    pend_txc <= win_txc[7:0];
  end

  ////////////////////
  // Output word

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      s1_valid    <= 1'b0;
      pend_valid  <= 1'b0;
      o_xgmii_txd <= {8{XGMII_IDLE}};
      o_xgmii_txc <= '1;
    end else begin
      s1_valid   <= i_beat_valid;
      // The framer gap keeps this slot free
      pend_valid <= s1_valid && s1_beat.eof;
      if (s1_valid) begin
        o_xgmii_txd <= win_txd[127:64];
        o_xgmii_txc <= win_txc[15:8];
      end else if (pend_valid) begin
        o_xgmii_txd <= pend_txd;
        o_xgmii_txc <= pend_txc;
      end else begin
        o_xgmii_txd <= {8{XGMII_IDLE}};
        o_xgmii_txc <= '1;
      end
    end
  end

endmodule
